/* rtl/pc_pkg.sv */
package pc_pkg;

  // ==========================================================
  // fetch address geometry
  // ==========================================================

  typedef logic [31:0] pc_address_t;          // fetch or commit byte address
  typedef logic [5:0]  block_offset_t;        // byte offset within a fetch block

  localparam int BLOCK_OFFSET_BITS = 6;       // 64 byte fetch block
  localparam int SLOTS             = 4;       // instruction slots per fetch group
  localparam int INDEX_LSB         = 12;      // table index starts here

  // one fetch group as presented by the fetch unit
  typedef struct packed {
    pc_address_t pc;                          // fetch block address
    pc_address_t pc0;                         // slot 0
    pc_address_t pc1;
    pc_address_t pc2;
    pc_address_t pc3;                         // slot 3
    pc_address_t pc4;                         // first address past the group
  } fetch_group_t;

endpackage

/* rtl/btb_pkg.sv */
package btb_pkg;

  // ==========================================================
  // table storage types
  // ==========================================================

  // one slot position of a table line
  typedef struct packed {
    logic                taken;               // branch was taken at commit
    pc_pkg::pc_address_t pc;                  // full address of the branch
    pc_pkg::pc_address_t tgt;                 // branch target
  } btb_entry_t;

  // ==========================================================
  // commit side types
  // ==========================================================

  // one committed slot, as handed over by the commit logic
  typedef struct packed {
    logic                taken;
    pc_pkg::pc_address_t pc;                  // committed address
    pc_pkg::pc_address_t tgt;                 // resolved target
  } commit_slot_t;

  typedef commit_slot_t [pc_pkg::SLOTS-1:0] commit_bundle_t;  // slot 0 in bits [64:0]
  typedef btb_entry_t   [pc_pkg::SLOTS-1:0] btb_line_t;       // same slot order

endpackage

/* rtl/btb_commit_stage.sv */
module btb_commit_stage #(
  parameter int DEPTH = 64
) (
  input  logic                        clk,
  input  logic                        rst,
  input  btb_pkg::commit_bundle_t     commit,
  output logic                        wr_en,
  output logic [$clog2(DEPTH)-1:0]    wr_index,
  output btb_pkg::btb_line_t          wr_line
);

  import pc_pkg::*;

  localparam int INDEX_BITS = $clog2(DEPTH);

  logic any_taken;                            // one or more slots taken this cycle

  // the whole line is rewritten whenever a slot in it was taken
  always_comb begin
    any_taken = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      any_taken = any_taken | commit[i].taken;
    end
  end

  // ==========================================================
  // write request register
  // ==========================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= any_taken;
    end
  end

  // payload is only meaningful while wr_en is high
  always_ff @(posedge clk) begin
    wr_index <= commit[0].pc[INDEX_LSB +: INDEX_BITS];  // line chosen by slot 0
    for (int i = 0; i < SLOTS; i++) begin
      wr_line[i].taken <= commit[i].taken;    // not-taken slots clear old predictions
      wr_line[i].pc    <= commit[i].pc;
      wr_line[i].tgt   <= commit[i].tgt;
    end
  end

  // a bundle seen during reset must not turn into a write afterwards
  a_no_write_after_rst : assert property (@(posedge clk) $past(rst) |-> !wr_en)
    else $error("btb_commit_stage: wr_en high in the cycle after reset");

endmodule

/* rtl/btb_table.sv */
module btb_table #(
  parameter int DEPTH = 64
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_en,
  input  logic [$clog2(DEPTH)-1:0]    wr_index,
  input  btb_pkg::btb_line_t          wr_line,
  input  logic [$clog2(DEPTH)-1:0]    rd_index,
  output btb_pkg::btb_line_t          rd_line,
  output logic                        rd_valid
);

  import btb_pkg::*;

  localparam int INDEX_BITS = $clog2(DEPTH);

  btb_line_t             lines [DEPTH];       // four entries per line
  logic [DEPTH-1:0]      line_valid;          // set on first write
  logic [INDEX_BITS-1:0] rd_index_q;          // registered lookup index

  // ==========================================================
  // storage
  // ==========================================================

  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[wr_index] <= wr_line;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;                       // empty table never hits
    end else if (wr_en) begin
      line_valid[wr_index] <= 1'b1;
    end
  end

  // ==========================================================
  // lookup
  // ==========================================================

  // lookup index for the read in the following cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else begin
      rd_index_q <= rd_index;
    end
  end

  assign rd_line  = lines[rd_index_q];        // data for the index taken at the last edge
  assign rd_valid = line_valid[rd_index_q];

  // write index comes from the commit stage register
  a_wr_index_known : assert property (@(posedge clk) wr_en |-> !$isunknown(wr_index))
    else $error("btb_table: wr_index unknown during a write");

endmodule

/* rtl/btb_predict.sv */
module btb_predict (
  input  pc_pkg::fetch_group_t fetch,
  input  btb_pkg::btb_line_t   rd_line,
  input  logic                 rd_valid,
  input  logic                 branchmiss,
  input  pc_pkg::pc_address_t  misspc,
  output pc_pkg::pc_address_t  next_pc,
  output logic                 takb
);

  import pc_pkg::*;

  localparam int PC_BITS = $bits(pc_address_t);

  typedef logic [PC_BITS-BLOCK_OFFSET_BITS-1:0] block_addr_t;  // address above the offset

  pc_address_t   slot_pc [SLOTS];             // fetch address per slot
  logic [SLOTS-1:0] slot_hit;                 // address match on a taken entry
  block_addr_t   fetch_block;
  block_addr_t   end_block;
  block_offset_t end_offset;
  pc_address_t   seq_pc;                      // fall-through address

  assign slot_pc[0] = fetch.pc0;
  assign slot_pc[1] = fetch.pc1;
  assign slot_pc[2] = fetch.pc2;
  assign slot_pc[3] = fetch.pc3;

  // ==========================================================
  // per slot compare
  // ==========================================================

  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      slot_hit[i] = rd_valid && rd_line[i].taken && (rd_line[i].pc == slot_pc[i]);
    end
  end

  // ==========================================================
  // sequential address
  // ==========================================================

  assign fetch_block = fetch.pc[PC_BITS-1:BLOCK_OFFSET_BITS];
  assign end_block   = fetch.pc4[PC_BITS-1:BLOCK_OFFSET_BITS];
  assign end_offset  = fetch.pc4[BLOCK_OFFSET_BITS-1:0];

  // group end stays in the block, else start of the next block
  assign seq_pc = (end_block == fetch_block) ? {fetch_block, end_offset}
                                             : {fetch_block + 1'b1, block_offset_t'(0)};

  // ==========================================================
  // next fetch select
  // ==========================================================

  always_comb begin
    next_pc = seq_pc;
    takb    = 1'b0;
    // walk down so the lowest hitting slot is applied last
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (slot_hit[i]) begin
        next_pc = rd_line[i].tgt;
        takb    = 1'b1;
      end
    end
    if (branchmiss) begin                     // redirect beats any prediction
      next_pc = misspc;
      takb    = 1'b1;
    end
  end

  // a predicted redirect always has a table hit behind it
  always_comb begin
    if (!branchmiss) begin
      a_takb_has_hit : assert (!takb || (|slot_hit))
        else $error("btb_predict: takb without a slot hit");
    end
  end

endmodule

/* rtl/btb_top.sv */
module btb_top #(
  parameter int DEPTH = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  btb_pkg::commit_bundle_t commit,
  input  pc_pkg::fetch_group_t    fetch,
  input  logic                    branchmiss,
  input  pc_pkg::pc_address_t     misspc,
  output pc_pkg::pc_address_t     next_pc,
  output logic                    takb
);

  import pc_pkg::*;
  import btb_pkg::*;

  localparam int INDEX_BITS = $clog2(DEPTH);

  logic                  wr_en;
  logic [INDEX_BITS-1:0] wr_index;
  btb_line_t             wr_line;
  logic [INDEX_BITS-1:0] lookup_index;        // line picked by fetch slot 0
  btb_line_t             rd_line;
  logic                  rd_valid;

  assign lookup_index = fetch.pc0[INDEX_LSB +: INDEX_BITS];

  // ==========================================================
  // commit -> table -> predict
  // ==========================================================

  btb_commit_stage #(.DEPTH(DEPTH)) btb_commit_stage_i (
    .clk      (clk),
    .rst      (rst),
    .commit   (commit),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_line  (wr_line)
  );

  btb_table #(.DEPTH(DEPTH)) btb_table_i (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_line  (wr_line),
    .rd_index (lookup_index),
    .rd_line  (rd_line),
    .rd_valid (rd_valid)
  );

  btb_predict btb_predict_i (
    .fetch      (fetch),
    .rd_line    (rd_line),
    .rd_valid   (rd_valid),
    .branchmiss (branchmiss),
    .misspc     (misspc),
    .next_pc    (next_pc),
    .takb       (takb)
  );

endmodule

/* sim/btb_tb.sv */
module btb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import pc_pkg::*;
  import btb_pkg::*;

  localparam int    HALF_PERIOD = 20;            // 40 ns clock
  localparam int    DRIVE_DELAY = 2;             // inputs change this long after the edge
  localparam string CASE_FILE   = "sim/btb_cases.txt";

  // one line of the case file, commit or lookup
  typedef struct packed {
    logic           is_commit;
    commit_bundle_t commit;
    logic [31:0]    num;                         // test number, lookups only
    logic           bm;
    pc_address_t    misspc;
    fetch_group_t   fetch;
    pc_address_t    exp_next;
    logic           exp_takb;
  } case_rec_t;

  logic           clk;
  logic           rst;
  commit_bundle_t commit;
  fetch_group_t   fetch;
  logic           branchmiss;
  pc_address_t    misspc;
  pc_address_t    next_pc;
  logic           takb;

  case_rec_t cases [$];
  int        pass_count  = 0;
  int        fail_count  = 0;
  int        test_count  = 0;
  int        cycle_count = 0;
  int        cycle_limit = 0;                    // 0 until the case file is loaded
  logic      load_error  = 1'b0;

  btb_top #(.DEPTH(64)) btb_top_i (
    .clk        (clk),
    .rst        (rst),
    .commit     (commit),
    .fetch      (fetch),
    .branchmiss (branchmiss),
    .misspc     (misspc),
    .next_pc    (next_pc),
    .takb       (takb)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // watchdog limit follows the number of cases
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ============================================================
  // case file
  // ============================================================

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v [12];
    case_rec_t   rec;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the case file %s", CASE_FILE);
      load_error = 1'b1;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") continue;
      rec = '0;
      if (line[0] == "C") begin                  // taken, address, target per slot
        n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                    v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
        rec.is_commit = 1'b1;
        for (int i = 0; i < SLOTS; i++) begin
          rec.commit[i].taken = v[3*i][0];
          rec.commit[i].pc    = v[3*i+1];
          rec.commit[i].tgt   = v[3*i+2];
        end
        if (n != 12) load_error = 1'b1;
      end else if (line[0] == "L") begin
        n = $sscanf(line, "L %d %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                    v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        rec.num       = v[0];
        rec.bm        = v[1][0];
        rec.misspc    = v[2];
        rec.fetch     = {v[3], v[4], v[5], v[6], v[7], v[8]};  // pc first, pc4 last
        rec.exp_next  = v[9];
        rec.exp_takb  = v[10][0];
        test_count++;
        if (n != 11) load_error = 1'b1;
      end else begin
        load_error = 1'b1;
      end
      if (load_error) begin
        $display("malformed line in the case file: %s", line);
        break;
      end
      cases.push_back(rec);
    end
    $fclose(fd);
    if (!load_error && test_count == 0) begin
      $display("the case file holds no lookup records");
      load_error = 1'b1;
    end
  endtask

  // ============================================================
  // driver and checker
  // ============================================================

  task automatic apply_commit(input case_rec_t c);
    commit = c.commit;
    @(posedge clk);                              // bundle sampled here
    #DRIVE_DELAY;
    commit = '0;                                 // all slots back to not taken
    repeat (2) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_lookup(input case_rec_t c);
    int errs;
    errs       = 0;
    fetch      = c.fetch;
    branchmiss = c.bm;
    misspc     = c.misspc;
    @(posedge clk);                              // lookup index registered
    #HALF_PERIOD;                                // read data settled mid cycle
    assert (next_pc === c.exp_next) else begin
      $display("ERROR %0d ns next_pc expected %h actual %h", $time, c.exp_next, next_pc);
      errs++;
    end
    assert (takb === c.exp_takb) else begin
      $display("ERROR %0d ns takb expected %b actual %b", $time, c.exp_takb, takb);
      errs++;
    end
    if (errs == 0) begin
      pass_count++;
      $display("test %0d: ok", c.num);
    end else begin
      fail_count++;
      $display("test %0d: mismatch", c.num);
    end
    @(posedge clk);                              // second held cycle
    #DRIVE_DELAY;
  endtask

  initial begin
    rst        = 1'b1;
    commit     = '0;
    fetch      = '0;
    branchmiss = 1'b0;
    misspc     = '0;
    load_cases();
    if (!load_error) begin
      cycle_limit = 6 * cases.size() + 20;
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      foreach (cases[k]) begin
        if (cases[k].is_commit) apply_commit(cases[k]);
        else check_lookup(cases[k]);
      end
    end
    $display("pass count %0d, fail count %0d", pass_count, fail_count);
    if (fail_count == 0 && !load_error) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim/btb_cases.txt */
# C t0 pc0 tgt0 t1 pc1 tgt1 t2 pc2 tgt2 t3 pc3 tgt3          commit, slot 0 first, hex
# L test bm misspc pc pc0 pc1 pc2 pc3 pc4 exp_next_pc exp_takb   lookup, test in decimal
#
# empty table, group end inside the fetch block
L 1 0 00000000 00001000 00001000 00001004 00001008 0000100c 00001010 00001010 0
# empty table, group ends on the next block boundary
L 2 0 00000000 00002030 00002030 00002034 00002038 0000203c 00002040 00002040 0
# group end past the boundary, next block starts at offset 0
L 3 0 00000000 00002034 00002034 00002038 0000203c 00002040 00002044 00002040 0
# branch miss with an empty table
L 4 1 dead0000 00001000 00001000 00001004 00001008 0000100c 00001010 dead0000 1
#
# line 3, slot 2 taken
C 0 00003000 00000000 0 00003004 00000000 1 00003008 00005000 0 0000300c 00000000
L 5 0 00000000 00003000 00003000 00003004 00003008 0000300c 00003010 00005000 1
# line 4 never written
L 6 0 00000000 00004000 00004000 00004004 00004008 0000400c 00004010 00004010 0
# line 3 valid, slot addresses differ
L 7 0 00000000 00003020 00003020 00003024 00003028 0000302c 00003030 00003030 0
# same index from higher address bits, full compare misses
L 8 0 00000000 00043000 00043000 00043004 00043008 0004300c 00043010 00043010 0
#
# line 6, slots 1 and 3 taken, slot 1 wins
C 0 00006100 00000000 1 00006104 00007000 0 00006108 00000000 1 0000610c 00008000
L 9 0 00000000 00006100 00006100 00006104 00006108 0000610c 00006110 00007000 1
# branch miss beats a hitting slot
L 10 1 0009abc0 00006100 00006100 00006104 00006108 0000610c 00006110 0009abc0 1
#
# line 3 rewritten, only slot 3 taken
C 0 00003010 00000000 0 00003014 00000000 0 00003018 00000000 1 0000301c 0000b000
# old slot 2 branch gone, sequential again
L 11 0 00000000 00003000 00003000 00003004 00003008 0000300c 00003010 00003010 0
L 12 0 00000000 00003010 00003010 00003014 00003018 0000301c 00003020 0000b000 1
# line 6 untouched by the rewrite
L 13 0 00000000 00006100 00006100 00006104 00006108 0000610c 00006110 00007000 1

/* files.f */
rtl/pc_pkg.sv
rtl/btb_pkg.sv
rtl/btb_commit_stage.sv
rtl/btb_table.sv
rtl/btb_predict.sv
rtl/btb_top.sv
sim/btb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the BTB testbench with Verilator from the project root

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module btb_tb -f files.f -o btb_sim > build.log 2>&1 &&
./obj_dir/btb_sim > sim.log 2>&1 ||
echo "build or simulation did not complete, see build.log and sim.log"

cat sim.log 2> /dev/null

grep -q "^Test passed$" sim.log 2> /dev/null &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
